//--- Bender.yml
package:
  name: laji_core

sources:
  - logic/laji_pkg.sv
  - logic/fetch_stage.sv
  - logic/decoder.sv
  - logic/register_file.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/laji_core.sv
  - target: test
    files:
      - tests/laji_core_tb.sv

//--- logic/decoder.sv
module decoder import laji_pkg::*; (
    input  logic [31:0] instruction,
    output ctrl_t       ctrl,
    output logic [4:0]  rs,
    output logic [4:0]  rt,
    output logic [15:0] imm16,
    output logic [4:0]  shamt,
    output logic [25:0] jump_index
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rd;
    logic       r_alu;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign rd = instruction[15:11];
    assign imm16 = instruction[15:0];
    assign shamt = instruction[10:6];
    assign jump_index = instruction[25:0];

    always_comb begin
        // zero control is a no-op, so unknown encodings fall through as bubbles
        ctrl = '0;
        r_alu = 1'b0;
        rs = '0;
        rt = '0;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: begin
                        ctrl.alu_op = alu_add;
                        r_alu = 1'b1;
                    end
                    fn_subu: begin
                        ctrl.alu_op = alu_sub;
                        r_alu = 1'b1;
                    end
                    fn_and: begin
                        ctrl.alu_op = alu_and;
                        r_alu = 1'b1;
                    end
                    fn_or: begin
                        ctrl.alu_op = alu_or;
                        r_alu = 1'b1;
                    end
                    fn_slt: begin
                        ctrl.alu_op = alu_slt;
                        r_alu = 1'b1;
                    end
                    fn_sll: begin
                        ctrl.alu_op = alu_sll;
                        ctrl.reg_write = 1'b1;
                        ctrl.dest = rd;
                        rt = instruction[20:16];
                    end
                    fn_jr: begin
                        ctrl.branch_op = br_jump_reg;
                        rs = instruction[25:21];
                    end
                    fn_syscall: begin
                        // service code and argument come through the normal read path
                        ctrl.syscall = 1'b1;
                        rs = reg_v0;
                        rt = reg_a0;
                    end
                    default: ;
                endcase
                if (r_alu) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.dest = rd;
                    rs = instruction[25:21];
                    rt = instruction[20:16];
                end
            end
            op_addiu, op_ori, op_lui, op_lw: begin
                ctrl.reg_write = 1'b1;
                ctrl.dest = instruction[20:16];
                rs = (opcode == op_lui) ? 5'd0 : instruction[25:21];
                ctrl.operand_b = (opcode == op_ori || opcode == op_lui) ?
                                 opb_zero_imm : opb_sign_imm;
                ctrl.alu_op = (opcode == op_ori) ? alu_or :
                              (opcode == op_lui) ? alu_lui : alu_add;
                ctrl.mem_read = (opcode == op_lw);
                ctrl.wb_src = (opcode == op_lw) ? wb_memory : wb_alu;
            end
            op_sw: begin
                ctrl.operand_b = opb_sign_imm;
                ctrl.mem_write = 1'b1;
                rs = instruction[25:21];
                rt = instruction[20:16];
            end
            op_beq, op_bne: begin
                ctrl.branch_op = (opcode == op_beq) ? br_beq : br_bne;
                rs = instruction[25:21];
                rt = instruction[20:16];
            end
            op_j: ctrl.branch_op = br_jump;
            op_jal: begin
                ctrl.branch_op = br_jump;
                ctrl.wb_src = wb_link;
                ctrl.reg_write = 1'b1;
                ctrl.dest = reg_ra;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/execute_stage.sv
module execute_stage import laji_pkg::*; (
    input  id_ex_t      id_ex,
    input  fwd_sel_e    fwd_a,
    input  fwd_sel_e    fwd_b,
    input  logic [31:0] mem_result,
    input  logic [31:0] wb_result,
    output ex_mem_t     ex_mem
);

    logic [31:0] rs_value;
    logic [31:0] rt_value;
    logic [31:0] operand_b;
    logic [31:0] sign_imm;
    logic [31:0] zero_imm;
    logic [31:0] alu_result;
    logic [31:0] target;

    function automatic logic [31:0] forward(fwd_sel_e sel, logic [31:0] reg_value,
                                            logic [31:0] mem_value, logic [31:0] wb_value);
        case (sel)
            fwd_memory: return mem_value;
            fwd_writeback: return wb_value;
            default: return reg_value;
        endcase
    endfunction

    assign rs_value = forward(fwd_a, id_ex.rs_value, mem_result, wb_result);
    assign rt_value = forward(fwd_b, id_ex.rt_value, mem_result, wb_result);

    assign sign_imm = {{16{id_ex.imm16[15]}}, id_ex.imm16};
    assign zero_imm = {16'd0, id_ex.imm16};

    always_comb begin
        case (id_ex.ctrl.operand_b)
            opb_sign_imm: operand_b = sign_imm;
            opb_zero_imm: operand_b = zero_imm;
            default: operand_b = rt_value;
        endcase
    end

    ////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_sub: alu_result = rs_value - operand_b;
            alu_and: alu_result = rs_value & operand_b;
            alu_or: alu_result = rs_value | operand_b;
            alu_slt: alu_result = {31'd0, $signed(rs_value) < $signed(operand_b)};
            alu_sll: alu_result = operand_b << id_ex.shamt;
            alu_lui: alu_result = {operand_b[15:0], 16'd0};
            default: alu_result = rs_value + operand_b;
        endcase
    end

    // branch offset counts words from pc+4
    always_comb begin
        case (id_ex.ctrl.branch_op)
            br_jump: target = {id_ex.pc_4[31:28], id_ex.jump_index, 2'b00};
            br_jump_reg: target = rs_value;
            default: target = id_ex.pc_4 + {sign_imm[29:0], 2'b00};
        endcase
    end

    always_comb begin
        ex_mem.valid = id_ex.valid;
        ex_mem.pc_4 = id_ex.pc_4;
        ex_mem.ctrl = id_ex.ctrl;
        ex_mem.alu_result = alu_result;
        ex_mem.store_data = rt_value;
        ex_mem.target = target;
        ex_mem.rs_value = rs_value;
        ex_mem.rt_value = rt_value;
    end

endmodule

//--- logic/fetch_stage.sv
module fetch_stage import laji_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  logic                      stall,
    input  logic                      halt,
    input  logic                      redirect,
    input  logic [31:0]               redirect_pc,
    input  logic                      load_en,
    input  logic [imem_addr_bits-1:0] load_addr,
    input  logic [31:0]               load_data,
    output if_id_t                    if_id
);

    logic [31:0] imem [2**imem_addr_bits];
    logic [31:0] pc;

    // program load works even while the core sits in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (en) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!stall && !halt) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // fetched word is dropped when halted or when a redirect is taken
    always_comb begin
        if_id.valid = !halt && !redirect;
        if_id.pc_4 = pc + 32'd4;
        if_id.instruction = imem[pc[imem_addr_bits+1:2]];
    end

endmodule

//--- logic/hazard_unit.sv
module hazard_unit import laji_pkg::*; (
    input  logic [4:0] id_rs,
    input  logic [4:0] id_rt,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    output logic       stall_id,
    output fwd_sel_e   fwd_a,
    output fwd_sel_e   fwd_b
);

    logic [4:0] load_dest;

    // memory stage wins over write-back and its loads are never forwarded
    function automatic fwd_sel_e select_source(logic [4:0] src, ex_mem_t em, mem_wb_t mw);
        if (src == 5'd0) begin
            return fwd_regfile;
        end
        if (em.valid && em.ctrl.reg_write && !em.ctrl.mem_read && em.ctrl.dest == src) begin
            return fwd_memory;
        end
        if (mw.valid && mw.ctrl.reg_write && mw.ctrl.dest == src) begin
            return fwd_writeback;
        end
        return fwd_regfile;
    endfunction

    ////////////////////////////////////////////////
    // load-use bubble
    ////////////////////////////////////////////////

    assign load_dest = id_ex.ctrl.dest;

    assign stall_id = id_ex.valid && id_ex.ctrl.mem_read && (load_dest != 5'd0) &&
                      (load_dest == id_rs || load_dest == id_rt);

    assign fwd_a = select_source(id_ex.rs, ex_mem, mem_wb);
    assign fwd_b = select_source(id_ex.rt, ex_mem, mem_wb);

endmodule

//--- logic/laji_core.sv
module laji_core import laji_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      en,
    input  logic                      load_en,
    input  logic [imem_addr_bits-1:0] load_addr,
    input  logic [31:0]               load_data,
    output logic [31:0]               display,
    output logic                      display_valid,
    output logic                      halt
);

    if_id_t  if_id_next;
    if_id_t  if_id_q;
    id_ex_t  id_ex_next;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_next;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_next;
    mem_wb_t mem_wb_q;

    ctrl_t       id_ctrl;
    logic [4:0]  id_rs;
    logic [4:0]  id_rt;
    logic [15:0] id_imm16;
    logic [4:0]  id_shamt;
    logic [25:0] id_jump_index;
    logic [31:0] rs_value;
    logic [31:0] rt_value;

    logic        stall_id;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;
    logic        redirect;
    logic [31:0] redirect_pc;

    ////////////////////////////////////////////////
    // fetch
    ////////////////////////////////////////////////

    fetch_stage u_fetch (
        .clk(clk),
        .reset(reset),
        .en(en),
        .stall(stall_id),
        .halt(halt),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .if_id(if_id_next)
    );

    // redirect beats stall and fetch already marks that word invalid
    always_ff @(posedge clk) begin
        if (reset) begin
            if_id_q <= '0;
        end else if (en && (redirect || !stall_id)) begin
            if_id_q <= if_id_next;
        end
    end

    ////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////

    decoder u_decoder (
        .instruction(if_id_q.instruction),
        .ctrl(id_ctrl),
        .rs(id_rs),
        .rt(id_rt),
        .imm16(id_imm16),
        .shamt(id_shamt),
        .jump_index(id_jump_index)
    );

    register_file u_regfile (
        .clk(clk),
        .reset(reset),
        .en(en),
        .write_en(mem_wb_q.valid && mem_wb_q.ctrl.reg_write),
        .write_reg(mem_wb_q.ctrl.dest),
        .write_data(mem_wb_q.write_data),
        .read_reg_a(id_rs),
        .read_reg_b(id_rt),
        .read_data_a(rs_value),
        .read_data_b(rt_value)
    );

    hazard_unit u_hazard (
        .id_rs(id_rs),
        .id_rt(id_rt),
        .id_ex(id_ex_q),
        .ex_mem(ex_mem_q),
        .mem_wb(mem_wb_q),
        .stall_id(stall_id),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

    always_comb begin
        id_ex_next.valid = if_id_q.valid;
        id_ex_next.pc_4 = if_id_q.pc_4;
        id_ex_next.ctrl = id_ctrl;
        id_ex_next.rs = id_rs;
        id_ex_next.rt = id_rt;
        id_ex_next.rs_value = rs_value;
        id_ex_next.rt_value = rt_value;
        id_ex_next.imm16 = id_imm16;
        id_ex_next.shamt = id_shamt;
        id_ex_next.jump_index = id_jump_index;
    end

    // bubble on load-use or misprediction
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex_q <= '0;
        end else if (en) begin
            id_ex_q <= (redirect || stall_id) ? '0 : id_ex_next;
        end
    end

    ////////////////////////////////////////////////
    // execute, memory, write-back
    ////////////////////////////////////////////////

    execute_stage u_execute (
        .id_ex(id_ex_q),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .mem_result(mem_wb_next.write_data),
        .wb_result(mem_wb_q.write_data),
        .ex_mem(ex_mem_next)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_mem_q <= '0;
        end else if (en) begin
            ex_mem_q <= redirect ? '0 : ex_mem_next;
        end
    end

    memory_stage u_memory (
        .clk(clk),
        .reset(reset),
        .en(en),
        .ex_mem(ex_mem_q),
        .mem_wb(mem_wb_next),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .display(display),
        .display_valid(display_valid),
        .halt(halt)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb_q <= '0;
        end else if (en) begin
            mem_wb_q <= mem_wb_next;
        end
    end

endmodule

//--- logic/laji_pkg.sv
package laji_pkg;

    // word-addressed memory depths
    localparam int imem_addr_bits = 8;
    localparam int dmem_addr_bits = 8;

    // fixed register numbers
    localparam logic [4:0] reg_v0 = 5'd2;
    localparam logic [4:0] reg_a0 = 5'd4;
    localparam logic [4:0] reg_ra = 5'd31;

    // syscall service codes held in v0
    localparam logic [31:0] sys_print = 32'd1;
    localparam logic [31:0] sys_exit = 32'd10;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_jr      = 6'h08,
        fn_syscall = 6'h0c,
        fn_addu    = 6'h21,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_slt     = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_jump, br_jump_reg
    } branch_op_e;

    typedef enum logic [1:0] {wb_alu, wb_memory, wb_link} wb_src_e;

    typedef enum logic [1:0] {opb_register, opb_sign_imm, opb_zero_imm} operand_b_e;

    typedef enum logic [1:0] {fwd_regfile, fwd_memory, fwd_writeback} fwd_sel_e;

    ////////////////////////////////////////////////
    // pipeline records
    ////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e    alu_op;
        branch_op_e branch_op;
        operand_b_e operand_b;
        wb_src_e    wb_src;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       syscall;
        logic [4:0] dest;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_4;
        logic [31:0] instruction;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_4;
        ctrl_t       ctrl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [15:0] imm16;
        logic [4:0]  shamt;
        logic [25:0] jump_index;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc_4;
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [31:0] target;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] write_data;
    } mem_wb_t;

endpackage

//--- logic/memory_stage.sv
module memory_stage import laji_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  ex_mem_t     ex_mem,
    output mem_wb_t     mem_wb,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic [31:0] display,
    output logic        display_valid,
    output logic        halt
);

    logic [31:0] dmem [2**dmem_addr_bits];
    logic [dmem_addr_bits-1:0] addr;
    logic [31:0] load_data;
    logic        active;
    logic        taken;
    logic        show;

    // anything younger than a halting syscall is squashed here
    assign active = ex_mem.valid && !halt;
    assign addr = ex_mem.alu_result[dmem_addr_bits+1:2];
    assign load_data = dmem[addr];

    always_ff @(posedge clk) begin
        if (en && active && ex_mem.ctrl.mem_write) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    ////////////////////////////////////////////////
    // branch resolution
    ////////////////////////////////////////////////

    always_comb begin
        case (ex_mem.ctrl.branch_op)
            br_beq: taken = (ex_mem.rs_value == ex_mem.rt_value);
            br_bne: taken = (ex_mem.rs_value != ex_mem.rt_value);
            br_jump, br_jump_reg: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = active && taken;
    assign redirect_pc = ex_mem.target;

    always_comb begin
        mem_wb.valid = active;
        mem_wb.ctrl = ex_mem.ctrl;
        case (ex_mem.ctrl.wb_src)
            wb_memory: mem_wb.write_data = load_data;
            wb_link: mem_wb.write_data = ex_mem.pc_4;
            default: mem_wb.write_data = ex_mem.alu_result;
        endcase
    end

    // rs carries v0 and rt carries a0 for a syscall
    assign show = active && ex_mem.ctrl.syscall && ex_mem.rs_value == sys_print;

    always_ff @(posedge clk) begin
        if (reset) begin
            display <= '0;
            display_valid <= 1'b0;
            halt <= 1'b0;
        end else begin
            display_valid <= en && show;
            if (en && show) begin
                display <= ex_mem.rt_value;
            end
            if (en && active && ex_mem.ctrl.syscall && ex_mem.rs_value == sys_exit) begin
                halt <= 1'b1;
            end
        end
    end

endmodule

//--- logic/register_file.sv
module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,
    input  logic        write_en,
    input  logic [4:0]  write_reg,
    input  logic [31:0] write_data,
    input  logic [4:0]  read_reg_a,
    input  logic [4:0]  read_reg_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b
);

    logic [31:0] regs [32];
    logic        writing;

    assign writing = write_en && (write_reg != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (en && writing) begin
            regs[write_reg] <= write_data;
        end
    end

    // bypass the write in flight
    assign read_data_a = (writing && write_reg == read_reg_a) ? write_data : regs[read_reg_a];
    assign read_data_b = (writing && write_reg == read_reg_b) ? write_data : regs[read_reg_b];

endmodule

//--- tests/laji_core_tb.sv
module laji_core_tb import laji_pkg::*; ();

    // MIPS register numbers used by the program
    localparam logic [4:0] r_zero = 5'd0;
    localparam logic [4:0] r_v0 = 5'd2;
    localparam logic [4:0] r_a0 = 5'd4;
    localparam logic [4:0] r_t0 = 5'd8;
    localparam logic [4:0] r_t1 = 5'd9;
    localparam logic [4:0] r_t2 = 5'd10;
    localparam logic [4:0] r_t3 = 5'd11;
    localparam logic [4:0] r_t4 = 5'd12;
    localparam logic [4:0] r_t5 = 5'd13;
    localparam logic [4:0] r_t6 = 5'd14;
    localparam logic [4:0] r_t7 = 5'd15;
    localparam logic [4:0] r_s0 = 5'd16;
    localparam logic [4:0] r_ra = 5'd31;

    logic                      clk;
    logic                      reset;
    logic                      en;
    logic                      load_en;
    logic [imem_addr_bits-1:0] load_addr;
    logic [31:0]               load_data;
    logic [31:0]               display;
    logic                      display_valid;
    logic                      halt;

    logic [31:0] program_words [$];
    logic [31:0] expected_display [$];

    int          value_errors = 0;
    int          sequence_errors = 0;
    int          strobe_count = 0;
    int          cycle_limit = 0;
    int          cycles = 0;
    logic        running = 1'b0;
    logic        halt_seen = 1'b0;
    int unsigned rand_seed;

    laji_core DUT (
        .clk(clk),
        .reset(reset),
        .en(en),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .display(display),
        .display_valid(display_valid),
        .halt(halt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    function automatic logic [31:0] encode_r(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd, logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] encode_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // word index of the target with the upper pc bits left zero
    function automatic logic [31:0] encode_j(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    task automatic emit(logic [31:0] word);
        program_words.push_back(word);
    endtask

    task automatic assemble_program();
        // dependent alu chain from word 0
        emit(encode_i(op_addiu, r_zero, r_t0, 16'd5));
        emit(encode_i(op_addiu, r_t0, r_t1, 16'd7));
        emit(encode_r(fn_subu, r_t1, r_t0, r_t2, 5'd0));
        emit(encode_r(fn_sll, r_zero, r_t2, r_t3, 5'd4));
        emit(encode_r(fn_or, r_t3, r_t2, r_a0, 5'd0));
        emit(encode_i(op_addiu, r_zero, r_v0, 16'd1));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // constant from lui and ori masked with a sign-extended value at word 7
        emit(encode_i(op_lui, r_zero, r_t4, 16'h1234));
        emit(encode_i(op_ori, r_t4, r_t4, 16'h5678));
        emit(encode_i(op_addiu, r_zero, r_t5, 16'hff00));
        emit(encode_r(fn_and, r_t4, r_t5, r_a0, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // signed compare both ways from word 12
        emit(encode_r(fn_slt, r_t5, r_t0, r_t6, 5'd0));
        emit(encode_r(fn_slt, r_t0, r_t5, r_t7, 5'd0));
        emit(encode_r(fn_sll, r_zero, r_t6, r_t6, 5'd3));
        emit(encode_r(fn_addu, r_t6, r_t7, r_a0, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_r(fn_subu, r_t0, r_t1, r_a0, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // store then load and a load-use pair from word 19
        emit(encode_i(op_addiu, r_zero, r_s0, 16'h0040));
        emit(encode_i(op_sw, r_s0, r_t4, 16'd4));
        emit(encode_i(op_lw, r_s0, r_t0, 16'd4));
        emit(encode_i(op_addiu, r_t0, r_a0, 16'd1));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_sw, r_s0, r_t2, 16'd0));
        emit(encode_i(op_lw, r_s0, r_a0, 16'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // beq not taken and bne taken to word 34
        emit(encode_i(op_beq, r_t2, r_t1, 16'd2));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0011));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_bne, r_t2, r_t1, 16'd3));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0099));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0098));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0022));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // beq taken to word 41 on a forwarded operand and bne not taken
        emit(encode_r(fn_addu, r_t2, r_zero, r_t3, 5'd0));
        emit(encode_i(op_beq, r_t3, r_t2, 16'd3));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0077));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_bne, r_t3, r_t2, 16'd2));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0033));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // j and jal to word 52 with the return through jr
        emit(encode_j(op_j, 26'd47));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_j(op_jal, 26'd52));
        emit(encode_i(op_addiu, r_zero, r_a0, 16'h0044));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_j(op_j, 26'd56));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_r(fn_addu, r_ra, r_zero, r_a0, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_r(fn_jr, r_ra, r_zero, r_zero, 5'd0));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        // exit at word 56 and a print behind it that must never fire
        emit(encode_i(op_addiu, r_zero, r_v0, 16'd10));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(encode_i(op_addiu, r_zero, r_v0, 16'd1));
        emit(encode_r(fn_syscall, r_zero, r_zero, r_zero, 5'd0));
        emit(32'h0000_0000);
        emit(32'h0000_0000);
    endtask

    // a0 at each print in program order
    task automatic fill_expected();
        expected_display.push_back(32'h0000_0077);
        expected_display.push_back(32'h1234_5600);
        expected_display.push_back(32'h0000_0008);
        expected_display.push_back(32'hffff_fff9);
        expected_display.push_back(32'h1234_5679);
        expected_display.push_back(32'h0000_0007);
        expected_display.push_back(32'h0000_0011);
        expected_display.push_back(32'h0000_0022);
        expected_display.push_back(32'h0000_0033);
        expected_display.push_back(32'h0000_00c0);
        expected_display.push_back(32'h0000_0044);
    endtask

    //////////////////////////////////////////////////
    // display monitor
    //////////////////////////////////////////////////

    task automatic check_strobe();
        if (halt_seen) begin
            $display("display strobe with value %h arrived after halt", display);
            sequence_errors++;
        end else if (strobe_count >= expected_display.size()) begin
            $display("unexpected extra display strobe with value %h", display);
            sequence_errors++;
        end else if (display !== expected_display[strobe_count]) begin
            $display("ERROR %0t: display strobe %0d shows %h, expected %h",
                     $time, strobe_count, display, expected_display[strobe_count]);
            value_errors++;
        end
        strobe_count++;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (display_valid) begin
                check_strobe();
            end
            if (halt) begin
                halt_seen = 1'b1;
            end
        end
    end

    initial begin : watchdog
        wait (running);
        while (!halt_seen && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!halt_seen) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            $display("error counts: %0d value, %0d sequence, %0d of %0d strobes seen",
                     value_errors, sequence_errors, strobe_count, expected_display.size());
            $display("Finished with errors");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        en = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        rand_seed = 32'h6938;
        void'($urandom(rand_seed));
        assemble_program();
        fill_expected();
        cycle_limit = 8 * program_words.size() + 100;

        // program goes in while the core sits in reset
        for (int i = 0; i < program_words.size(); i++) begin
            @(posedge clk);
            #2;
            load_en = 1'b1;
            load_addr = i[imem_addr_bits-1:0];
            load_data = program_words[i];
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        running = 1'b1;

        // freeze the core now and then
        while (!halt_seen) begin
            @(posedge clk);
            #2;
            en = ($urandom % 10) != 0;
        end
        en = 1'b1;
        // watch for stray strobes after halt
        repeat (10) @(posedge clk);

        if (strobe_count < expected_display.size()) begin
            $display("only %0d of %0d display strobes arrived before halt",
                     strobe_count, expected_display.size());
            sequence_errors++;
        end
        $display("error counts: %0d value, %0d sequence, %0d of %0d strobes seen",
                 value_errors, sequence_errors, strobe_count, expected_display.size());
        if (value_errors == 0 && sequence_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/laji_pkg.sv
logic/fetch_stage.sv
logic/decoder.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/laji_core.sv
tests/laji_core_tb.sv
